// ==== src/conv_geom_pkg.sv ====
`default_nettype none

package conv_geom_pkg;

  // Block and kernel geometry
  localparam int ROWS       = 4;
  localparam int KH_MAX     = 5;
  localparam int EDGE_WORDS = KH_MAX / 2;
  localparam int WORD_WIDTH = 8;

  // Room for KH_MAX taps without overflow
  localparam int SUM_WIDTH = WORD_WIDTH + $clog2(KH_MAX);

  // Image limits
  localparam int IM_CIN_MAX    = 8;
  localparam int IM_COLS_MAX   = 16;
  localparam int IM_BLOCKS_MAX = 4;

  // Counter widths
  localparam int BITS_KH     = $clog2(KH_MAX);
  localparam int BITS_KH2    = $clog2((KH_MAX + 1) / 2);
  localparam int BITS_CIN    = $clog2(IM_CIN_MAX);
  localparam int BITS_COLS   = $clog2(IM_COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(IM_BLOCKS_MAX);

  localparam int COLUMN_WORDS    = ROWS + EDGE_WORDS;
  localparam int SHIFT_WORDS     = ROWS + KH_MAX - 1;
  localparam int EDGE_DEPTH      = IM_CIN_MAX * IM_COLS_MAX;
  localparam int EDGE_ADDR_WIDTH = $clog2(EDGE_DEPTH);

endpackage

`default_nettype wire

// ==== src/conv_stream_pkg.sv ====
`default_nettype none

package conv_stream_pkg;

  import conv_geom_pkg::*;

  // Sits in the low bits of the CONFIG beat, kh2 lowest
  typedef struct packed {
    logic [BITS_BLOCKS-1:0] blocks_last;
    logic [BITS_COLS-1:0]   cols_last;
    logic [BITS_CIN-1:0]    cin_last;
    logic [BITS_KH2-1:0]    kh2;
  } conv_cfg_t;

  // Word 0 is the top row
  typedef struct packed {
    logic [COLUMN_WORDS-1:0][WORD_WIDTH-1:0] words;
  } column_t;

  typedef struct packed {
    logic [EDGE_WORDS-1:0][WORD_WIDTH-1:0] words;
  } edge_t;

  typedef struct packed {
    logic [WORD_WIDTH-1:0] tap;
    logic                  first;
    logic                  last;
  } lane_tap_t;

  typedef logic [SUM_WIDTH-1:0] lane_sum_t;

  typedef struct packed {
    lane_sum_t [ROWS-1:0] sums;
  } result_t;

  typedef enum logic [1:0] {
    CONFIG,
    PASS,
    DRAIN
  } streamer_state_e;

endpackage

`default_nettype wire

// ==== src/edge_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_ram
  import conv_geom_pkg::*, conv_stream_pkg::*;
(
  input  logic                       aclk,
  input  logic                       rd_en,
  input  logic [EDGE_ADDR_WIDTH-1:0] rd_addr,
  output edge_t                      rd_data,
  input  logic                       wr_en,
  input  logic [EDGE_ADDR_WIDTH-1:0] wr_addr,
  input  edge_t                      wr_data
);

  // One entry per channel and column
  edge_t mem [EDGE_DEPTH];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data holds until the next rd_en
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== src/pixel_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_streamer
  import conv_geom_pkg::*, conv_stream_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 s_valid,
  input  logic                 s_last,
  input  column_t              s_data,
  output logic                 s_ready,
  input  logic                 step_en,
  output lane_tap_t [ROWS-1:0] taps,
  output logic                 tap_valid,
  output logic                 group_last
);

  streamer_state_e state_q;
  conv_cfg_t       cfg_q;
  conv_cfg_t       cfg_in;

  logic [$bits(column_t)-1:0] s_bits;

  logic [BITS_KH-1:0]         kh_cnt_q;
  logic [BITS_CIN-1:0]        cin_cnt_q;
  logic [BITS_COLS-1:0]       col_cnt_q;
  logic [BITS_BLOCKS-1:0]     blk_cnt_q;
  logic [EDGE_ADDR_WIDTH-1:0] addr_q;

  logic cin_wrap;
  logic col_wrap;
  logic first_blk;
  logic last_blk;
  logic take_cfg;
  logic take_col;
  logic tap_last;
  logic tap_valid_q;
  logic frame_last_q;
  logic [1:0] fin_q;

  logic [SHIFT_WORDS-1:0][WORD_WIDTH-1:0] shift_q;

  logic  rd_en;
  logic  wr_en;
  edge_t rd_data;
  edge_t wr_data;
  edge_t halo;

  assign s_bits = s_data;
  assign cfg_in = s_bits[$bits(conv_cfg_t)-1:0];

  always_comb begin
    unique case (state_q)
      CONFIG:  s_ready = 1'b1;
      // Next column waits until the current group has shifted out
      PASS:    s_ready = step_en && !tap_valid_q;
      default: s_ready = 1'b0;
    endcase
  end

  assign take_cfg = (state_q == CONFIG) && s_valid;
  assign take_col = (state_q == PASS) && s_valid && s_ready;

  // fin_q counts the two steps from the final tap to the last beat transfer
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= CONFIG;
      fin_q   <= 2'd0;
    end else begin
      unique case (state_q)
        CONFIG: if (s_valid) state_q <= PASS;
        PASS:   if (take_col && s_last) state_q <= DRAIN;
        DRAIN:  if (step_en && fin_q == 2'd2) state_q <= CONFIG;
        default: state_q <= CONFIG;
      endcase
      if (step_en) begin
        if (group_last) begin
          fin_q <= 2'd1;
        end else if (fin_q == 2'd1) begin
          fin_q <= 2'd2;
        end else if (fin_q == 2'd2) begin
          fin_q <= 2'd0;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg_q <= '0;
    end else if (take_cfg) begin
      cfg_q <= cfg_in;
    end
  end

  // Channel, column and block counters advance per accepted column
  assign cin_wrap  = cin_cnt_q == cfg_q.cin_last;
  assign col_wrap  = cin_wrap && (col_cnt_q == cfg_q.cols_last);
  assign first_blk = blk_cnt_q == '0;
  assign last_blk  = blk_cnt_q == cfg_q.blocks_last;

  always_ff @(posedge aclk) begin
    if (!aresetn || take_cfg) begin
      cin_cnt_q <= '0;
      col_cnt_q <= '0;
      blk_cnt_q <= '0;
      addr_q    <= '0;
    end else if (take_col) begin
      cin_cnt_q <= cin_wrap ? '0 : cin_cnt_q + 1'b1;
      if (cin_wrap) begin
        col_cnt_q <= (col_cnt_q == cfg_q.cols_last) ? '0 : col_cnt_q + 1'b1;
      end
      if (col_wrap) begin
        blk_cnt_q <= last_blk ? '0 : blk_cnt_q + 1'b1;
      end
      addr_q <= col_wrap ? '0 : addr_q + 1'b1;
    end
  end

  // Read runs ahead, so halo is ready when the column arrives
  assign rd_en         = (state_q == PASS) && !first_blk;
  assign wr_en         = take_col && !last_blk;
  assign wr_data.words = s_data.words[ROWS-1:ROWS-EDGE_WORDS];
  assign halo          = first_blk ? '0 : rd_data;

  edge_ram u_edge_ram (
    .aclk    (aclk),
    .rd_en   (rd_en),
    .rd_addr (addr_q),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (addr_q),
    .wr_data (wr_data)
  );

  assign tap_last = kh_cnt_q == BITS_KH'(2 * cfg_q.kh2);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tap_valid_q  <= 1'b0;
      kh_cnt_q     <= '0;
      frame_last_q <= 1'b0;
    end else if (step_en) begin
      if (take_col) begin
        tap_valid_q  <= 1'b1;
        kh_cnt_q     <= '0;
        frame_last_q <= s_last;
      end else if (tap_valid_q) begin
        if (tap_last) begin
          tap_valid_q <= 1'b0;
        end
        kh_cnt_q <= kh_cnt_q + 1'b1;
      end
    end
  end

  // Halo on top, then the column
  always_ff @(posedge aclk) begin
    if (take_col) begin
      shift_q <= {s_data.words, halo.words};
    end else if (step_en && tap_valid_q) begin
      shift_q <= shift_q >> WORD_WIDTH;
    end
  end

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      taps[r].tap   = shift_q[r + EDGE_WORDS - int'(cfg_q.kh2)];
      taps[r].first = kh_cnt_q == '0;
      taps[r].last  = tap_last;
    end
  end

  assign tap_valid  = tap_valid_q;
  assign group_last = tap_valid_q && tap_last && frame_last_q;

endmodule

`default_nettype wire

// ==== src/row_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_accum
  import conv_stream_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      step_en,
  input  lane_tap_t tap,
  input  logic      tap_valid,
  output lane_sum_t sum,
  output logic      sum_valid
);

  lane_sum_t acc_q;
  lane_sum_t acc_next;

  // A first tap starts a fresh sum
  always_comb begin
    if (tap.first) begin
      acc_next = lane_sum_t'(tap.tap);
    end else begin
      acc_next = acc_q + lane_sum_t'(tap.tap);
    end
  end

  always_ff @(posedge aclk) begin
    if (step_en && tap_valid) begin
      acc_q <= acc_next;
    end
  end

  always_ff @(posedge aclk) begin
    if (step_en && tap_valid && tap.last) begin
      sum <= acc_next;
    end
  end

  // Valid for one step after the last tap
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sum_valid <= 1'b0;
    end else if (step_en) begin
      sum_valid <= tap_valid && tap.last;
    end
  end

endmodule

`default_nettype wire

// ==== src/result_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_packer
  import conv_geom_pkg::*, conv_stream_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  lane_sum_t [ROWS-1:0] sums,
  input  logic                 sum_valid,
  input  logic                 group_last,
  output logic                 step_en,
  output logic                 m_valid,
  output logic                 m_last,
  output result_t              m_data,
  input  logic                 m_ready
);

  // Final group seen, its sums not yet captured
  logic last_pend_q;

  // Empty, or the held beat leaves this cycle
  assign step_en = !m_valid || m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid     <= 1'b0;
      m_last      <= 1'b0;
      last_pend_q <= 1'b0;
    end else if (step_en) begin
      m_valid <= sum_valid;
      m_last  <= sum_valid && last_pend_q;
      if (sum_valid) begin
        last_pend_q <= 1'b0;
      end
      if (group_last) begin
        last_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (step_en && sum_valid) begin
      m_data.sums <= sums;
    end
  end

endmodule

`default_nettype wire

// ==== src/conv_rows_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_rows_top
  import conv_geom_pkg::*, conv_stream_pkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,
  input  logic    s_valid,
  output logic    s_ready,
  input  logic    s_last,
  input  column_t s_data,
  output logic    m_valid,
  input  logic    m_ready,
  output logic    m_last,
  output result_t m_data
);

  lane_tap_t [ROWS-1:0] taps;
  lane_sum_t [ROWS-1:0] lane_sum;
  logic      [ROWS-1:0] lane_valid;
  logic                 tap_valid;
  logic                 group_last;
  logic                 step_en;
  logic                 all_valid;

  pixel_streamer u_streamer (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_data     (s_data),
    .s_ready    (s_ready),
    .step_en    (step_en),
    .taps       (taps),
    .tap_valid  (tap_valid),
    .group_last (group_last)
  );

  for (genvar r = 0; r < ROWS; r++) begin : g_lane
    row_accum u_lane (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .step_en   (step_en),
      .tap       (taps[r]),
      .tap_valid (tap_valid),
      .sum       (lane_sum[r]),
      .sum_valid (lane_valid[r])
    );
  end

  // Lanes run in lockstep
  assign all_valid = &lane_valid;

  result_packer u_packer (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .sums       (lane_sum),
    .sum_valid  (all_valid),
    .group_last (group_last),
    .step_en    (step_en),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_data     (m_data),
    .m_ready    (m_ready)
  );

endmodule

`default_nettype wire

// ==== tests/conv_rows_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_rows_chk
  import conv_stream_pkg::*;
(
  input logic    aclk,
  input logic    aresetn,
  input logic    s_ready,
  input logic    m_valid,
  input logic    m_ready,
  input logic    m_last,
  input result_t m_data
);

  int unsigned fail_cnt = 0;

  // Held beat stays put under back-pressure
  hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
      m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
    else begin
      $error("m_data or m_last changed while the beat was stalled");
      fail_cnt++;
    end

  reset_idle: assert property (@(posedge aclk) !aresetn |=> !m_valid)
    else begin
      $error("m_valid high in the cycle after reset");
      fail_cnt++;
    end

  // Streamer sits in DRAIN until the last beat leaves
  drain_block: assert property (@(posedge aclk) disable iff (!aresetn)
      m_valid && m_last && !m_ready |-> !s_ready)
    else begin
      $error("s_ready high while the last beat was held");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== tests/tb_conv_rows.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_rows
  import conv_geom_pkg::*, conv_stream_pkg::*;
();

  // Config beats plus columns over all directed tests
  localparam int TEST_BEATS      = 7 + 13 + 7 + 25 + 10;
  localparam int WATCHDOG_CYCLES = TEST_BEATS * KH_MAX * 4 + 300;

  logic    aclk = 1'b0;
  logic    aresetn;
  logic    s_valid;
  logic    s_ready;
  logic    s_last;
  column_t s_data;
  logic    m_valid;
  logic    m_ready;
  logic    m_last;
  result_t m_data;

  int          err_cnt   = 0;
  logic [31:0] lcg_state = 32'd68872;
  column_t     frame_cols[$];
  result_t     exp_q[$];
  logic        exp_last_q[$];

  always #2 aclk = ~aclk;

  conv_rows_top dut0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  bind conv_rows_top conv_rows_chk chk0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Lane r adds 2*kh2+1 words of the halo-extended column
  task automatic build_expected(input int kh2, input int cin, input int cols);
    logic [WORD_WIDTH-1:0] ext [EDGE_WORDS + COLUMN_WORDS];
    column_t prev;
    result_t res;
    exp_q.delete();
    exp_last_q.delete();
    for (int i = 0; i < frame_cols.size(); i++) begin
      if (i < cin * cols) begin
        prev = '0;
      end else begin
        prev = frame_cols[i - cin * cols];
      end
      for (int k = 0; k < EDGE_WORDS; k++) ext[k] = prev.words[ROWS - EDGE_WORDS + k];
      for (int k = 0; k < COLUMN_WORDS; k++) ext[EDGE_WORDS + k] = frame_cols[i].words[k];
      for (int r = 0; r < ROWS; r++) begin
        res.sums[r] = '0;
        for (int j = 0; j <= 2 * kh2; j++) res.sums[r] += ext[r + EDGE_WORDS - kh2 + j];
      end
      exp_q.push_back(res);
      exp_last_q.push_back(i == frame_cols.size() - 1);
    end
  endtask

  task automatic send_beat(input column_t data, input logic last);
    s_valid = 1'b1;
    s_data  = data;
    s_last  = last;
    @(posedge aclk);
    while (!s_ready) @(posedge aclk);
    #0.5;
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  // Ready is high 5 times in 8 when stalling
  task automatic collect_beats(input bit stall);
    result_t     exp_beat;
    logic        exp_last;
    logic [31:0] rnd;
    int          last_wait;
    last_wait = 0;
    while (exp_q.size() > 0) begin
      @(posedge aclk);
      if (m_valid && m_ready) begin
        exp_beat = exp_q.pop_front();
        exp_last = exp_last_q.pop_front();
        check_eq("m_data", m_data, exp_beat);
        check_eq("m_last", m_last, exp_last);
      end
      #0.5;
      rnd     = next_random();
      m_ready = !stall || (rnd[18:16] > 3'd2);
      // The final beat is held back a few cycles
      if (stall && m_valid && exp_q.size() == 1 && last_wait < 3) begin
        m_ready = 1'b0;
        last_wait++;
      end
    end
    m_ready = 1'b1;
  endtask

  task automatic run_frame(input int kh2, input int cin, input int cols, input int blocks,
                           input bit stall);
    conv_cfg_t                  cfg;
    logic [$bits(column_t)-1:0] cfg_bits;
    logic [31:0]                rnd;
    column_t                    col;
    frame_cols.delete();
    for (int i = 0; i < blocks * cols * cin; i++) begin
      for (int k = 0; k < COLUMN_WORDS; k++) begin
        rnd          = next_random();
        col.words[k] = rnd[23:16];
      end
      frame_cols.push_back(col);
    end
    build_expected(kh2, cin, cols);
    cfg.kh2         = BITS_KH2'(kh2);
    cfg.cin_last    = BITS_CIN'(cin - 1);
    cfg.cols_last   = BITS_COLS'(cols - 1);
    cfg.blocks_last = BITS_BLOCKS'(blocks - 1);
    cfg_bits        = '0;
    cfg_bits[$bits(conv_cfg_t)-1:0] = cfg;
    fork
      begin
        send_beat(cfg_bits, 1'b0);
        for (int i = 0; i < frame_cols.size(); i++) begin
          send_beat(frame_cols[i], i == frame_cols.size() - 1);
        end
      end
      collect_beats(stall);
    join
    // Nothing may follow the last beat
    repeat (2 * KH_MAX) begin
      @(posedge aclk);
      check_eq("m_valid", m_valid, 1'b0);
    end
    #0.5;
  endtask

  initial begin
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_data  = '0;
    m_ready = 1'b1;
    repeat (3) @(posedge aclk);
    #0.5;
    aresetn = 1'b1;
    @(posedge aclk);
    check_eq("m_valid", m_valid, 1'b0);
    check_eq("s_ready", s_ready, 1'b1);
    #0.5;
    run_frame(1, 2, 3, 1, 1'b0);
    // Halo carried across three blocks
    run_frame(2, 2, 2, 3, 1'b0);
    // Single tap so each lane sees its own row
    run_frame(0, 1, 3, 2, 1'b0);
    run_frame(1, 3, 2, 4, 1'b1);
    // New kh2 right after a frame ends
    run_frame(2, 1, 2, 2, 1'b0);
    run_frame(1, 2, 1, 2, 1'b0);
    err_cnt += dut0.chk0.fail_cnt;
    $display("run complete, errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("timeout: run did not finish in %0d cycles, errors: %0d", WATCHDOG_CYCLES, err_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
src/conv_geom_pkg.sv
src/conv_stream_pkg.sv
src/edge_ram.sv
src/pixel_streamer.sv
src/row_accum.sv
src/result_packer.sv
src/conv_rows_top.sv
tests/conv_rows_chk.sv
tests/tb_conv_rows.sv

// ==== Bender.yml ====
package:
  name: conv_rows

sources:
  - src/conv_geom_pkg.sv
  - src/conv_stream_pkg.sv
  - src/edge_ram.sv
  - src/pixel_streamer.sv
  - src/row_accum.sv
  - src/result_packer.sv
  - src/conv_rows_top.sv
  - target: test
    files:
      - tests/conv_rows_chk.sv
      - tests/tb_conv_rows.sv
